// File: diag_router.sv
`default_nettype none

module diag_router #(
    parameter  int rows      = 3,
    parameter  int cols      = 4,
    parameter  int num_lines = 6,
    localparam int line_w    = (num_lines > 1) ? $clog2(num_lines) : 1
) (
    input  logic [rows-1:0][cols-1:0] pe_full,
    input  logic [line_w-1:0]         line_ptr,
    input  logic                      send,
    output logic                      line_ready,
    output logic [num_lines-1:0]      bus_valid
);

    // one bit per diagonal, set when any of its PEs is full
    logic [num_lines-1:0] diag_full;

    // PE (r, c) sits on diagonal r + c
    always_comb begin
        diag_full = '0;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                diag_full[r + c] = diag_full[r + c] | pe_full[r][c];
            end
        end
    end

    assign line_ready = ~diag_full[line_ptr];

    // only the bus of the current line may be valid
    always_comb begin
        bus_valid           = '0;
        bus_valid[line_ptr] = send;
    end

endmodule

`default_nettype wire

// File: files.f
noc_pkg.sv
noc_ctrl.sv
noc_read_counter.sv
ifmap_buffer.sv
diag_router.sv
noc_top.sv
noc_assert.sv
noc_checker.sv
tb_noc_top.sv

// File: ifmap_buffer.sv
`default_nettype none

module ifmap_buffer #(
    parameter  int num_lines  = 6,
    parameter  int line_elems = 8,
    localparam int line_w     = (num_lines > 1) ? $clog2(num_lines) : 1,
    localparam int group_w    = (line_elems / noc_pkg::pkt_elems > 1) ?
                                $clog2(line_elems / noc_pkg::pkt_elems) : 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  noc_pkg::op_mode_t     mode_in,
    input  logic [num_lines-1:0][line_elems-1:0][noc_pkg::data_w-1:0] ifmap_data_in,
    input  logic [line_w-1:0]     line_ptr,
    input  logic [group_w-1:0]    group_ptr,
    output logic [noc_pkg::pkt_elems-1:0][noc_pkg::data_w-1:0] bus_data
);

    import noc_pkg::*;

    logic [num_lines-1:0][line_elems-1:0][data_w-1:0] padded;
    logic [num_lines-1:0][line_elems-1:0][data_w-1:0] lines_q;
    logic [1:0]                                       shift;

    // lines and elements move down by the same amount
    always_comb begin
        case (mode_in)
            mode_pad1: shift = 2'd1;
            mode_pad2: shift = 2'd2;
            default:   shift = 2'd0;
        endcase
    end

    // zero fill the top rows and the leading elements
    always_comb begin
        for (int r = 0; r < num_lines; r++) begin
            for (int e = 0; e < line_elems; e++) begin
                if (r >= shift && e >= shift) begin
                    padded[r][e] = ifmap_data_in[r - shift][e - shift];
                end else begin
                    padded[r][e] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines_q <= '0;
        end else if (load) begin
            lines_q <= padded;
        end
    end

    // current packet, group_ptr picks the element window
    always_comb begin
        for (int i = 0; i < pkt_elems; i++) begin
            bus_data[i] = lines_q[line_ptr][group_ptr * pkt_elems + i];
        end
    end

endmodule

`default_nettype wire

// File: noc_assert.sv
`default_nettype none

module noc_assert #(
    parameter int num_lines = 6
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic [2:0]           state,
    input logic                 send,
    input logic                 line_ready,
    input logic [num_lines-1:0] bus_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // idle, load and stream codes
    state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state))
        else begin
            $error("controller state %b is not one-hot", state);
            fail_count++;
        end

    bus_single: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(bus_valid))
        else begin
            $error("more than one bus valid: %b", bus_valid);
            fail_count++;
        end

    // a packet only leaves when its diagonal has room
    send_ready: assert property (@(posedge clk) disable iff (!rst_n) send |-> line_ready)
        else begin
            $error("send while the current line is not ready");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: noc_cases.txt
# mode pe_full hold packets
# mode 0 pass, 1 pad one, 2 pad two, 3 unused code; pe_full bit r*4+c is PE (r, c)
0 000 0 12
1 000 0 12
2 000 0 12
3 000 0 12
0 001 5 12
1 010 8 12
2 800 3 12
0 020 6 12
1 fff 10 12
2 104 4 12
3 041 7 12
0 000 2 12

// File: noc_checker.sv
`default_nettype none

module noc_checker #(
    parameter  int rows       = 3,
    parameter  int cols       = 4,
    parameter  int line_elems = 8,
    localparam int num_lines  = rows + cols - 1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_conv,
    input  noc_pkg::op_mode_t         mode_in,
    input  logic [num_lines-1:0][line_elems-1:0][noc_pkg::data_w-1:0] ifmap_data_in,
    input  logic [rows-1:0][cols-1:0] pe_full,
    input  logic                      conv_complete,
    input  logic [num_lines-1:0]      bus_valid,
    input  logic [noc_pkg::pkt_elems-1:0][noc_pkg::data_w-1:0] bus_data,
    input  logic                      free_ifmap_buffer,
    input  logic                      busy,
    input  int                        exp_pkts,
    output int                        errors,
    output int                        cases_done
);

    timeunit 1ns;
    timeprecision 1ps;

    import noc_pkg::*;

    localparam int groups = line_elems / pkt_elems;

    // padded copy of the captured batch
    logic [num_lines-1:0][line_elems-1:0][data_w-1:0] ref_lines;
    logic [pkt_elems-1:0][data_w-1:0]                 exp_data;
    logic [num_lines-1:0]                             diag_full;
    logic started;
    logic in_case;
    logic prev_busy;
    logic prev_cc;
    int   shift;
    int   line;
    int   exp_line;
    int   exp_group;
    int   pkt_count;
    int   case_errs;
    int   case_mode;

    task automatic report_value(input string name, input logic [63:0] exp_v,
                                input logic [63:0] got_v);
        $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp_v, got_v);
        errors++;
        case_errs++;
    endtask

    task automatic report_issue(input string what);
        $display("ERROR t=%0t %s", $time, what);
        errors++;
        case_errs++;
    endtask

    task automatic capture_batch();
        case (mode_in)
            mode_pad1: shift = 1;
            mode_pad2: shift = 2;
            default:   shift = 0;
        endcase
        // line r takes line r-shift, moved up by shift elements
        for (int r = 0; r < num_lines; r++) begin
            for (int e = 0; e < line_elems; e++) begin
                if (r >= shift && e >= shift) begin
                    ref_lines[r][e] = ifmap_data_in[r - shift][e - shift];
                end else begin
                    ref_lines[r][e] = '0;
                end
            end
        end
        case_mode = int'(mode_in);
        exp_line  = 0;
        exp_group = 0;
        pkt_count = 0;
        case_errs = 0;
        started   = 1'b1;
        in_case   = 1'b1;
    endtask

    task automatic check_packet();
        line = 0;
        for (int d = 0; d < num_lines; d++) begin
            if (bus_valid[d]) begin
                line = d;
            end
        end
        if ($countones(bus_valid) > 1) begin
            report_issue("more than one bus valid in the same cycle");
        end
        if (!in_case || exp_group >= groups) begin
            report_issue("packet sent outside a stream or past the last group");
        end else begin
            if (line != exp_line) begin
                report_value("bus_valid", 64'(1) << exp_line, 64'(bus_valid));
            end
            for (int i = 0; i < pkt_elems; i++) begin
                exp_data[i] = ref_lines[line][exp_group * pkt_elems + i];
            end
            if (bus_data !== exp_data) begin
                report_value("bus_data", 64'(exp_data), 64'(bus_data));
            end
            pkt_count++;
            exp_line++;
            if (exp_line == num_lines) begin
                exp_line = 0;
                exp_group++;
            end
        end
    endtask

    task automatic finish_case();
        if (pkt_count != exp_pkts) begin
            report_value("packet count", 64'(exp_pkts), 64'(pkt_count));
        end
        $display("case %0d mode %0d: %0d packets, %0d errors",
                 cases_done, case_mode, pkt_count, case_errs);
        cases_done++;
        in_case = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            started    = 1'b0;
            in_case    = 1'b0;
            prev_busy  = 1'b0;
            prev_cc    = 1'b0;
            errors     = 0;
            cases_done = 0;
        end else begin
            // quiet outputs until the first batch
            if (!started && (busy || free_ifmap_buffer || bus_valid != '0)) begin
                report_value("{busy,free_ifmap_buffer,bus_valid}", 64'(0),
                             64'({busy, free_ifmap_buffer, bus_valid}));
            end
            if (free_ifmap_buffer !== prev_cc) begin
                report_value("free_ifmap_buffer", 64'(prev_cc), 64'(free_ifmap_buffer));
            end
            prev_cc = conv_complete;
            diag_full = '0;
            for (int r = 0; r < rows; r++) begin
                for (int c = 0; c < cols; c++) begin
                    if (pe_full[r][c]) begin
                        diag_full[r + c] = 1'b1;
                    end
                end
            end
            // no bus of a full diagonal may fire
            if ((bus_valid & diag_full) != '0) begin
                report_value("bus_valid", 64'(bus_valid & ~diag_full), 64'(bus_valid));
            end
            // busy drops in the cycle after the last packet
            if (in_case && exp_group == groups && busy) begin
                report_issue("busy still high after the last packet");
            end
            if (bus_valid != '0) begin
                check_packet();
            end
            if (prev_busy && !busy && in_case) begin
                finish_case();
            end
            if (start_conv && !busy) begin
                capture_batch();
            end
            prev_busy = busy;
        end
    end

endmodule

`default_nettype wire

// File: noc_ctrl.sv
`default_nettype none

module noc_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start_conv,
    input  logic conv_complete,
    input  logic line_ready,
    input  logic last,
    output logic load,
    output logic clear,
    output logic advance,
    output logic send,
    output logic busy,
    output logic free_ifmap_buffer
);

    // one-hot state codes
    localparam logic [2:0] st_idle   = 3'b001;
    localparam logic [2:0] st_load   = 3'b010;
    localparam logic [2:0] st_stream = 3'b100;

    logic [2:0] state;
    logic [2:0] state_next;
    logic       start_ok;

    // a start is only taken from idle
    assign start_ok = (state == st_idle) && start_conv;
    assign load     = start_ok;
    assign clear    = start_ok;

    // one packet per cycle while the current diagonal has room
    assign advance = (state == st_stream) && line_ready;
    assign send    = advance;

    assign busy = (state != st_idle);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start_ok) begin
                    state_next = st_load;
                end
            end
            // buffer is written on the edge that enters this state
            st_load: begin
                state_next = st_stream;
            end
            st_stream: begin
                if (advance && last) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // free follows every conv_complete, whatever the state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_ifmap_buffer <= 1'b0;
        end else begin
            free_ifmap_buffer <= conv_complete;
        end
    end

endmodule

`default_nettype wire

// File: noc_pkg.sv
`default_nettype none

package noc_pkg;

    // one feature-map element
    parameter int data_w = 8;

    // elements carried by one bus packet
    parameter int pkt_elems = 4;

    // zero padding applied when a batch is captured
    // code 2'b11 is not used and falls back to pass-through
    typedef enum logic [1:0] {
        mode_pass = 2'b00,
        mode_pad1 = 2'b01,
        mode_pad2 = 2'b10
    } op_mode_t;

endpackage

`default_nettype wire

// File: noc_read_counter.sv
`default_nettype none

module noc_read_counter #(
    parameter  int num_lines  = 6,
    parameter  int line_elems = 8,
    localparam int line_w     = (num_lines > 1) ? $clog2(num_lines) : 1,
    localparam int group_w    = (line_elems / noc_pkg::pkt_elems > 1) ?
                                $clog2(line_elems / noc_pkg::pkt_elems) : 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               advance,
    output logic [line_w-1:0]  line_ptr,
    output logic [group_w-1:0] group_ptr,
    output logic               last
);

    import noc_pkg::*;

    // element groups per line
    localparam int groups = line_elems / pkt_elems;

    logic line_end;
    logic group_end;

    assign line_end  = (line_ptr == line_w'(num_lines - 1));
    assign group_end = (group_ptr == group_w'(groups - 1));

    // final line of the final group
    assign last = line_end && group_end;

    // lines step fastest, the group steps when the line pointer wraps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_ptr  <= '0;
            group_ptr <= '0;
        end else if (clear) begin
            line_ptr  <= '0;
            group_ptr <= '0;
        end else if (advance) begin
            if (line_end) begin
                line_ptr <= '0;
                if (group_end) begin
                    group_ptr <= '0;
                end else begin
                    group_ptr <= group_ptr + group_w'(1);
                end
            end else begin
                line_ptr <= line_ptr + line_w'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: noc_top.sv
`default_nettype none

module noc_top #(
    parameter  int rows       = 3,
    parameter  int cols       = 4,
    parameter  int line_elems = 8,
    localparam int num_lines  = rows + cols - 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_conv,
    input  noc_pkg::op_mode_t     mode_in,
    input  logic [num_lines-1:0][line_elems-1:0][noc_pkg::data_w-1:0] ifmap_data_in,
    input  logic [rows-1:0][cols-1:0] pe_full,
    input  logic                  conv_complete,
    output logic [num_lines-1:0]  bus_valid,
    output logic [noc_pkg::pkt_elems-1:0][noc_pkg::data_w-1:0] bus_data,
    output logic                  free_ifmap_buffer,
    output logic                  busy
);

    import noc_pkg::*;

    localparam int groups  = line_elems / pkt_elems;
    localparam int line_w  = (num_lines > 1) ? $clog2(num_lines) : 1;
    localparam int group_w = (groups > 1) ? $clog2(groups) : 1;

    logic               load;
    logic               clear;
    logic               advance;
    logic               send;
    logic               last;
    logic               line_ready;
    logic [line_w-1:0]  line_ptr;
    logic [group_w-1:0] group_ptr;

    noc_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_conv        (start_conv),
        .conv_complete     (conv_complete),
        .line_ready        (line_ready),
        .last              (last),
        .load              (load),
        .clear             (clear),
        .advance           (advance),
        .send              (send),
        .busy              (busy),
        .free_ifmap_buffer (free_ifmap_buffer)
    );

    noc_read_counter #(
        .num_lines  (num_lines),
        .line_elems (line_elems)
    ) u_read_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .advance   (advance),
        .line_ptr  (line_ptr),
        .group_ptr (group_ptr),
        .last      (last)
    );

    ifmap_buffer #(
        .num_lines  (num_lines),
        .line_elems (line_elems)
    ) u_ifmap_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .load          (load),
        .mode_in       (mode_in),
        .ifmap_data_in (ifmap_data_in),
        .line_ptr      (line_ptr),
        .group_ptr     (group_ptr),
        .bus_data      (bus_data)
    );

    diag_router #(
        .rows      (rows),
        .cols      (cols),
        .num_lines (num_lines)
    ) u_diag_router (
        .pe_full    (pe_full),
        .line_ptr   (line_ptr),
        .send       (send),
        .line_ready (line_ready),
        .bus_valid  (bus_valid)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build with Verilator, run, and pass only on the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_noc_top -f files.f
out=$(./obj_dir/Vtb_noc_top)
echo "$out"
echo "$out" | grep -qx "TB PASSED"

// File: tb_noc_top.sv
`default_nettype none

module tb_noc_top;

    timeunit 1ns;
    timeprecision 1ps;

    import noc_pkg::*;

    localparam int rows       = 3;
    localparam int cols       = 4;
    localparam int line_elems = 8;
    localparam int num_lines  = rows + cols - 1;
    localparam int groups     = line_elems / pkt_elems;

    logic                                             clk;
    logic                                             rst_n;
    logic                                             start_conv;
    op_mode_t                                         mode_in;
    logic [num_lines-1:0][line_elems-1:0][data_w-1:0] ifmap_data_in;
    logic [rows-1:0][cols-1:0]                        pe_full;
    logic                                             conv_complete;
    logic [num_lines-1:0]                             bus_valid;
    logic [pkt_elems-1:0][data_w-1:0]                 bus_data;
    logic                                             free_ifmap_buffer;
    logic                                             busy;
    int                                               exp_pkts;
    int                                               errors;
    int                                               cases_done;

    // case table, one entry per line of the case file
    logic [1:0]           mode_q[$];
    logic [rows*cols-1:0] mask_q[$];
    int                   hold_q[$];
    int                   pkt_q[$];

    logic [15:0] lfsr_state;
    int          cycles;
    int          limit;

    noc_top #(
        .rows       (rows),
        .cols       (cols),
        .line_elems (line_elems)
    ) uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_conv        (start_conv),
        .mode_in           (mode_in),
        .ifmap_data_in     (ifmap_data_in),
        .pe_full           (pe_full),
        .conv_complete     (conv_complete),
        .bus_valid         (bus_valid),
        .bus_data          (bus_data),
        .free_ifmap_buffer (free_ifmap_buffer),
        .busy              (busy)
    );

    noc_checker #(
        .rows       (rows),
        .cols       (cols),
        .line_elems (line_elems)
    ) u_checker (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_conv        (start_conv),
        .mode_in           (mode_in),
        .ifmap_data_in     (ifmap_data_in),
        .pe_full           (pe_full),
        .conv_complete     (conv_complete),
        .bus_valid         (bus_valid),
        .bus_data          (bus_data),
        .free_ifmap_buffer (free_ifmap_buffer),
        .busy              (busy),
        .exp_pkts          (exp_pkts),
        .errors            (errors),
        .cases_done        (cases_done)
    );

    // controller checks sit inside the DUT top
    bind noc_top noc_assert #(.num_lines(num_lines)) u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (u_ctrl.state),
        .send       (send),
        .line_ready (line_ready),
        .bus_valid  (bus_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // galois form, taps for a 16 bit maximal sequence
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    task automatic make_batch(output logic [num_lines-1:0][line_elems-1:0][data_w-1:0] batch);
        for (int r = 0; r < num_lines; r++) begin
            for (int e = 0; e < line_elems; e++) begin
                for (int b = 0; b < data_w; b++) begin
                    batch[r][e][b] = lfsr_state[0];
                    lfsr_state = lfsr_step(lfsr_state);
                end
            end
        end
    endtask

    task automatic read_cases();
        int          fd;
        int          m;
        int          h;
        int          p;
        logic [31:0] msk;
        string       text;
        fd = $fopen("noc_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open noc_cases.txt");
        end else begin
            while ($fgets(text, fd) != 0) begin
                if (text.getc(0) != "#" && $sscanf(text, "%d %h %d %d", m, msk, h, p) == 4) begin
                    mode_q.push_back(m[1:0]);
                    mask_q.push_back(msk[rows*cols-1:0]);
                    hold_q.push_back(h);
                    pkt_q.push_back(p);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_case(input int k);
        logic [num_lines-1:0][line_elems-1:0][data_w-1:0] batch;
        make_batch(batch);
        @(posedge clk);
        exp_pkts      <= pkt_q[k];
        start_conv    <= 1'b1;
        mode_in       <= op_mode_t'(mode_q[k]);
        ifmap_data_in <= batch;
        pe_full       <= mask_q[k];
        @(posedge clk);
        start_conv <= 1'b0;
        @(posedge clk);
        while (!busy) begin
            @(posedge clk);
        end
        // a second start in mid stream, other data and mode
        make_batch(batch);
        start_conv    <= 1'b1;
        mode_in       <= op_mode_t'(mode_q[k] + 2'd1);
        ifmap_data_in <= batch;
        @(posedge clk);
        start_conv    <= 1'b0;
        conv_complete <= 1'b1;
        @(posedge clk);
        conv_complete <= 1'b0;
        for (int i = 2; i < hold_q[k]; i++) begin
            @(posedge clk);
        end
        pe_full <= '0;
        while (busy) begin
            @(posedge clk);
        end
        // free strobe while idle as well
        conv_complete <= 1'b1;
        @(posedge clk);
        conv_complete <= 1'b0;
    endtask

    initial begin
        int max_hold;
        rst_n         = 1'b0;
        start_conv    = 1'b0;
        mode_in       = mode_pass;
        ifmap_data_in = '0;
        pe_full       = '0;
        conv_complete = 1'b0;
        exp_pkts      = 0;
        lfsr_state    = 16'd16;
        max_hold      = 0;
        read_cases();
        foreach (hold_q[i]) begin
            if (hold_q[i] > max_hold) begin
                max_hold = hold_q[i];
            end
        end
        limit = hold_q.size() * (num_lines * groups + max_hold + 20);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        for (int k = 0; k < hold_q.size(); k++) begin
            run_case(k);
        end
        repeat (4) @(posedge clk);
        $display("cases %0d of %0d, checker errors %0d, assertion failures %0d",
                 cases_done, hold_q.size(), errors, uut.u_assert.fail_count);
        if (hold_q.size() > 0 && cases_done == hold_q.size() && errors == 0 &&
            uut.u_assert.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // run limit counts cycles after reset
    initial begin
        cycles = 0;
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            if (rst_n) begin
                cycles++;
            end
        end
        $display("timeout, the run did not end within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
